// File: sources.f
+incdir+tb
source/drive_pkg.sv
source/pulse_sequencer.sv
source/envelope_memory.sv
source/nco_bank.sv
source/polar_modulator.sv
source/drive_signal_gen.sv
tb/drive_signal_gen_tb.sv

// File: tb/drive_model.svh
`ifndef DRIVE_MODEL_SVH
`define DRIVE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// expected samples and model state
////////////////////////////////////////////////////////////////////////////

typedef struct packed {
    drive_pkg::iq_t iq;
    logic [7:0]     phase;
    logic [1:0]     qubit;
    logic [31:0]    due_edge;
} exp_sample_t;

drive_pkg::env_word_t    env_model   [drive_pkg::ENV_DEPTH];
drive_pkg::table_entry_t table_model [drive_pkg::NUM_QUBIT][drive_pkg::INST_TABLE_DEPTH];
drive_pkg::inst_word_t   inst_model  [drive_pkg::INST_LIST_DEPTH];
int                      ftw_model   [drive_pkg::NUM_QUBIT];
int                      ftw_edge    [drive_pkg::NUM_QUBIT];
int                      rz_sum      [drive_pkg::NUM_QUBIT];
exp_sample_t             exp_q[$];
int                      rz_expected;

// ramp table, lut[n] = n - 128
function automatic int lut_value(input int addr);
    return (addr % 256) - 128;
endfunction

// q from lut[p], i from lut[p + quarter turn], both scaled by amp
function automatic drive_pkg::iq_t calc_iq(input int amp, input int p);
    drive_pkg::iq_t result;
    int             i_prod;
    int             q_prod;
    q_prod = amp * lut_value(p);
    i_prod = amp * lut_value(p + int'(drive_pkg::QUARTER_TURN));
    q_prod = q_prod >>> drive_pkg::IQ_SHIFT;
    i_prod = i_prod >>> drive_pkg::IQ_SHIFT;
    result.q = q_prod[8:0];
    result.i = i_prod[8:0];
    return result;
endfunction

// top accumulator bits after the given edge
function automatic int nco_phase_at(input int qubit, input int edge_idx);
    int acc;
    acc = ((edge_idx - ftw_edge[qubit]) * ftw_model[qubit]) % 65536;
    return ((acc >> 8) + rz_sum[qubit]) % 256;
endfunction

function automatic void expect_inst(input int pc, input int accept_edge);
    drive_pkg::inst_word_t   inst;
    drive_pkg::table_entry_t entry;
    drive_pkg::env_word_t    word;
    exp_sample_t             smp;
    int                      count;
    int                      addr;
    int                      p;
    inst = inst_model[pc];
    if (inst.op == drive_pkg::OP_RZ) begin
        rz_sum[inst.qubit] = (rz_sum[inst.qubit] + int'(inst.phase_imm)) % 256;
        rz_expected++;
        return;
    end
    entry = table_model[inst.qubit][inst.phase_imm[2:0]];
    count = 1;
    if (entry.stop_addr >= entry.start_addr) begin
        count = int'(entry.stop_addr) - int'(entry.start_addr) + 1;
    end
    for (int j = 0; j < count; j++) begin
        addr = (int'(entry.start_addr) + j) % 256;
        word = env_model[addr];
        // nco is read while the word leaves the memory, accept + 4 + j
        p = (int'(word.phase) + nco_phase_at(inst.qubit, accept_edge + 4 + j)
             + int'(entry.axis) * int'(drive_pkg::QUARTER_TURN)) % 256;
        smp.iq       = calc_iq(int'(word.amp), p);
        smp.phase    = p[7:0];
        smp.qubit    = inst.qubit;
        smp.due_edge = accept_edge + 7 + j;
        exp_q.push_back(smp);
    end
endfunction

`endif

// File: tb/drive_signal_gen_tb.sv
`timescale 1ns/1ns

module drive_signal_gen_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int HALF_PERIOD     = CLK_PERIOD / 2;
    // memory fills, table and list writes, all bursts, overhead per instruction
    localparam int PROG_CYCLES     = 2 * drive_pkg::ENV_DEPTH + 2 * 17 + 10;
    localparam int BURST_CYCLES    = 90;
    localparam int NUM_INST        = 12;
    localparam int WATCHDOG_CYCLES = 2 * (PROG_CYCLES + BURST_CYCLES + 20 * NUM_INST);

    logic                                         clk;
    logic                                         rst;
    logic                                         pc_valid_i;
    logic [drive_pkg::PC_WIDTH-1:0]               pc_i;
    logic                                         inst_wr_en_i;
    logic [drive_pkg::PC_WIDTH-1:0]               inst_wr_addr_i;
    drive_pkg::inst_word_t                        inst_wr_data_i;
    logic                                         table_wr_en_i;
    logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       table_wr_qubit_i;
    logic [drive_pkg::INST_TABLE_ADDR_WIDTH-1:0]  table_wr_addr_i;
    drive_pkg::table_entry_t                      table_wr_data_i;
    logic                                         env_wr_en_i;
    logic [drive_pkg::ENV_ADDR_WIDTH-1:0]         env_wr_addr_i;
    drive_pkg::env_word_t                         env_wr_data_i;
    logic                                         lut_wr_en_i;
    logic [drive_pkg::PHASE_WIDTH-1:0]            lut_wr_addr_i;
    logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]  lut_wr_data_i;
    logic                                         ftw_wr_en_i;
    logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       ftw_qubit_i;
    logic [drive_pkg::NCO_WIDTH-1:0]              ftw_i;
    drive_pkg::iq_t                               iq_o;
    logic                                         sample_valid_o;
    logic                                         rz_done_o;
    logic                                         busy_o;

    int     mismatch_cnt;
    int     other_err_cnt;
    int     checked_cnt;
    int     rz_seen;
    integer seed;

    `include "drive_model.svh"

    drive_signal_gen i_dut (
        .clk              (clk),
        .rst              (rst),
        .pc_valid_i       (pc_valid_i),
        .pc_i             (pc_i),
        .inst_wr_en_i     (inst_wr_en_i),
        .inst_wr_addr_i   (inst_wr_addr_i),
        .inst_wr_data_i   (inst_wr_data_i),
        .table_wr_en_i    (table_wr_en_i),
        .table_wr_qubit_i (table_wr_qubit_i),
        .table_wr_addr_i  (table_wr_addr_i),
        .table_wr_data_i  (table_wr_data_i),
        .env_wr_en_i      (env_wr_en_i),
        .env_wr_addr_i    (env_wr_addr_i),
        .env_wr_data_i    (env_wr_data_i),
        .lut_wr_en_i      (lut_wr_en_i),
        .lut_wr_addr_i    (lut_wr_addr_i),
        .lut_wr_data_i    (lut_wr_data_i),
        .ftw_wr_en_i      (ftw_wr_en_i),
        .ftw_qubit_i      (ftw_qubit_i),
        .ftw_i            (ftw_i),
        .iq_o             (iq_o),
        .sample_valid_o   (sample_valid_o),
        .rz_done_o        (rz_done_o),
        .busy_o           (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // index of the rising edge at the current time
    function automatic int edge_now();
        return int'(($time - HALF_PERIOD) / CLK_PERIOD);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // programming tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fill_envelope();
        logic [31:0]          rnd;
        drive_pkg::env_word_t word;
        for (int a = 0; a < drive_pkg::ENV_DEPTH; a++) begin
            rnd  = $random(seed);
            word = rnd[15:0];
            @(posedge clk);
            env_wr_en_i   <= 1'b1;
            env_wr_addr_i <= a[7:0];
            env_wr_data_i <= word;
            env_model[a] = word;
        end
        @(posedge clk);
        env_wr_en_i <= 1'b0;
    endtask

    task automatic fill_sine_table();
        int val;
        for (int a = 0; a < 256; a++) begin
            val = a - 128;
            @(posedge clk);
            lut_wr_en_i   <= 1'b1;
            lut_wr_addr_i <= a[7:0];
            lut_wr_data_i <= val[7:0];
        end
        @(posedge clk);
        lut_wr_en_i <= 1'b0;
    endtask

    task automatic write_table(input int qubit, input int idx, input int start_addr,
                               input int stop_addr, input drive_pkg::axis_t axis);
        drive_pkg::table_entry_t entry;
        entry.start_addr = start_addr[7:0];
        entry.stop_addr  = stop_addr[7:0];
        entry.axis       = axis;
        @(posedge clk);
        table_wr_en_i    <= 1'b1;
        table_wr_qubit_i <= qubit[1:0];
        table_wr_addr_i  <= idx[2:0];
        table_wr_data_i  <= entry;
        table_model[qubit][idx] = entry;
        @(posedge clk);
        table_wr_en_i <= 1'b0;
    endtask

    task automatic write_inst(input int pc, input int qubit, input drive_pkg::op_t op,
                              input int imm);
        drive_pkg::inst_word_t inst;
        inst.qubit     = qubit[1:0];
        inst.op        = op;
        inst.phase_imm = imm[7:0];
        @(posedge clk);
        inst_wr_en_i   <= 1'b1;
        inst_wr_addr_i <= pc[5:0];
        inst_wr_data_i <= inst;
        inst_model[pc] = inst;
        @(posedge clk);
        inst_wr_en_i <= 1'b0;
    endtask

    // a tuning word write restarts the accumulator from zero
    task automatic write_ftw(input int qubit, input int ftw);
        @(posedge clk);
        ftw_wr_en_i <= 1'b1;
        ftw_qubit_i <= qubit[1:0];
        ftw_i       <= ftw[15:0];
        ftw_edge[qubit]  = edge_now() + 1;
        ftw_model[qubit] = ftw;
        rz_sum[qubit]    = 0;
        @(posedge clk);
        ftw_wr_en_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction issue
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (busy_o);
    endtask

    // called right after an edge with the sequencer idle
    task automatic issue_inst(input int pc);
        pc_valid_i <= 1'b1;
        pc_i       <= pc[5:0];
        expect_inst(pc, edge_now() + 1);
        @(posedge clk);
        pc_valid_i <= 1'b0;
    endtask

    task automatic poke_while_busy(input int pc);
        @(posedge clk);
        pc_valid_i <= 1'b1;
        pc_i       <= pc[5:0];
        @(posedge clk);
        if (!busy_o) begin
            $display("busy_o was low at %0t while an instruction was running", $time);
            other_err_cnt++;
        end
        pc_valid_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // comparison process
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        exp_sample_t exp_smp;
        if (!rst) begin
            if (rz_done_o) begin
                rz_seen++;
            end
            if (sample_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected sample at %0t: i=%0d q=%0d", $time, iq_o.i, iq_o.q);
                    other_err_cnt++;
                end else begin
                    exp_smp = exp_q.pop_front();
                    checked_cnt++;
                    if (iq_o !== exp_smp.iq || edge_now() != exp_smp.due_edge) begin
                        $display("Mismatch at %0t: qubit %0d p=%0d got i=%0d q=%0d at edge %0d",
                                 $time, exp_smp.qubit, exp_smp.phase, iq_o.i, iq_o.q,
                                 edge_now());
                        $display("    expected i=%0d q=%0d at edge %0d",
                                 exp_smp.iq.i, exp_smp.iq.q, exp_smp.due_edge);
                        mismatch_cnt++;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed             = 32'h2c1e_e428;
        rst              = 1'b1;
        pc_valid_i       = 1'b0;
        pc_i             = '0;
        inst_wr_en_i     = 1'b0;
        inst_wr_addr_i   = '0;
        inst_wr_data_i   = '0;
        table_wr_en_i    = 1'b0;
        table_wr_qubit_i = '0;
        table_wr_addr_i  = '0;
        table_wr_data_i  = '0;
        env_wr_en_i      = 1'b0;
        env_wr_addr_i    = '0;
        env_wr_data_i    = '0;
        lut_wr_en_i      = 1'b0;
        lut_wr_addr_i    = '0;
        lut_wr_data_i    = '0;
        ftw_wr_en_i      = 1'b0;
        ftw_qubit_i      = '0;
        ftw_i            = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fill_envelope();
        fill_sine_table();
        write_table(0, 0, 10, 17, drive_pkg::AXIS_X);
        write_table(0, 1, 40, 44, drive_pkg::AXIS_Y);
        write_table(0, 2, 60, 63, drive_pkg::AXIS_NX);
        write_table(0, 3, 80, 85, drive_pkg::AXIS_NY);
        // stop below start, single word
        write_table(0, 4, 100, 98, drive_pkg::AXIS_X);
        write_table(1, 0, 120, 129, drive_pkg::AXIS_X);
        write_table(2, 5, 150, 155, drive_pkg::AXIS_Y);
        write_table(3, 0, 200, 215, drive_pkg::AXIS_X);
        write_inst(0, 0, drive_pkg::OP_PULSE, 0);
        write_inst(1, 0, drive_pkg::OP_PULSE, 1);
        write_inst(2, 0, drive_pkg::OP_PULSE, 2);
        write_inst(3, 0, drive_pkg::OP_PULSE, 3);
        write_inst(4, 0, drive_pkg::OP_PULSE, 4);
        write_inst(5, 1, drive_pkg::OP_PULSE, 0);
        write_inst(6, 0, drive_pkg::OP_RZ, 8'h25);
        write_inst(7, 2, drive_pkg::OP_PULSE, 8'h05);
        write_inst(8, 3, drive_pkg::OP_PULSE, 0);

        // plain x burst, then one burst per axis
        for (int pc = 0; pc <= 4; pc++) begin
            wait_idle();
            issue_inst(pc);
        end

        // rz on qubit 0 moves later qubit 0 bursts only
        wait_idle();
        issue_inst(6);
        wait_idle();
        issue_inst(0);
        wait_idle();
        issue_inst(5);

        // nonzero tuning word on qubit 3
        wait_idle();
        write_ftw(3, 16'h0300);
        wait_idle();
        issue_inst(8);

        // strobe while busy, then back-to-back bursts on other qubits
        wait_idle();
        issue_inst(5);
        poke_while_busy(1);
        wait_idle();
        issue_inst(7);
        wait_idle();
        issue_inst(8);

        wait_idle();
        for (int n = 0; n < 20 && exp_q.size() > 0; n++) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (exp_q.size() > 0) begin
            $display("%0d expected samples never arrived", exp_q.size());
            other_err_cnt++;
        end
        if (rz_seen != rz_expected) begin
            $display("saw %0d rz_done_o pulses but expected %0d", rz_seen, rz_expected);
            other_err_cnt++;
        end
        $display("summary: %0d samples checked, %0d mismatches, %0d other errors",
                 checked_cnt, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: source/drive_signal_gen.sv
`timescale 1ns/1ns

module drive_signal_gen (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         pc_valid_i,
    input  logic [drive_pkg::PC_WIDTH-1:0]               pc_i,
    input  logic                                         inst_wr_en_i,
    input  logic [drive_pkg::PC_WIDTH-1:0]               inst_wr_addr_i,
    input  drive_pkg::inst_word_t                        inst_wr_data_i,
    input  logic                                         table_wr_en_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       table_wr_qubit_i,
    input  logic [drive_pkg::INST_TABLE_ADDR_WIDTH-1:0]  table_wr_addr_i,
    input  drive_pkg::table_entry_t                      table_wr_data_i,
    input  logic                                         env_wr_en_i,
    input  logic [drive_pkg::ENV_ADDR_WIDTH-1:0]         env_wr_addr_i,
    input  drive_pkg::env_word_t                         env_wr_data_i,
    input  logic                                         lut_wr_en_i,
    input  logic [drive_pkg::PHASE_WIDTH-1:0]            lut_wr_addr_i,
    input  logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]  lut_wr_data_i,
    input  logic                                         ftw_wr_en_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       ftw_qubit_i,
    input  logic [drive_pkg::NCO_WIDTH-1:0]              ftw_i,
    output drive_pkg::iq_t                               iq_o,
    output logic                                         sample_valid_o,
    output logic                                         rz_done_o,
    output logic                                         busy_o
);

    drive_pkg::env_read_t   env_read;
    drive_pkg::env_sample_t env_sample;
    drive_pkg::rz_cmd_t     rz_cmd;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer -> envelope memory -> modulator
    ////////////////////////////////////////////////////////////////////////////

    pulse_sequencer i_pulse_sequencer (
        .clk              (clk),
        .rst              (rst),
        .pc_valid_i       (pc_valid_i),
        .pc_i             (pc_i),
        .inst_wr_en_i     (inst_wr_en_i),
        .inst_wr_addr_i   (inst_wr_addr_i),
        .inst_wr_data_i   (inst_wr_data_i),
        .table_wr_en_i    (table_wr_en_i),
        .table_wr_qubit_i (table_wr_qubit_i),
        .table_wr_addr_i  (table_wr_addr_i),
        .table_wr_data_i  (table_wr_data_i),
        .env_read_o       (env_read),
        .rz_cmd_o         (rz_cmd),
        .busy_o           (busy_o)
    );

    envelope_memory i_envelope_memory (
        .clk          (clk),
        .wr_en_i      (env_wr_en_i),
        .wr_addr_i    (env_wr_addr_i),
        .wr_data_i    (env_wr_data_i),
        .env_read_i   (env_read),
        .env_sample_o (env_sample)
    );

    polar_modulator i_polar_modulator (
        .clk            (clk),
        .rst            (rst),
        .env_sample_i   (env_sample),
        .rz_cmd_i       (rz_cmd),
        .lut_wr_en_i    (lut_wr_en_i),
        .lut_wr_addr_i  (lut_wr_addr_i),
        .lut_wr_data_i  (lut_wr_data_i),
        .ftw_wr_en_i    (ftw_wr_en_i),
        .ftw_qubit_i    (ftw_qubit_i),
        .ftw_i          (ftw_i),
        .iq_o           (iq_o),
        .sample_valid_o (sample_valid_o),
        .rz_done_o      (rz_done_o)
    );

endmodule

// File: source/polar_modulator.sv
`timescale 1ns/1ns

module polar_modulator (
    input  logic                                         clk,
    input  logic                                         rst,
    input  drive_pkg::env_sample_t                       env_sample_i,
    input  drive_pkg::rz_cmd_t                           rz_cmd_i,
    input  logic                                         lut_wr_en_i,
    input  logic [drive_pkg::PHASE_WIDTH-1:0]            lut_wr_addr_i,
    input  logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]  lut_wr_data_i,
    input  logic                                         ftw_wr_en_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       ftw_qubit_i,
    input  logic [drive_pkg::NCO_WIDTH-1:0]              ftw_i,
    output drive_pkg::iq_t                               iq_o,
    output logic                                         sample_valid_o,
    output logic                                         rz_done_o
);

    logic [drive_pkg::PHASE_WIDTH-1:0]                          nco_phase;
    logic [drive_pkg::PHASE_WIDTH-1:0]                          sin_addr;
    logic [drive_pkg::PHASE_WIDTH-1:0]                          cos_addr;
    logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]                lut [2**drive_pkg::PHASE_WIDTH];
    logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]                sin_q;
    logic signed [drive_pkg::LUT_DATA_WIDTH-1:0]                cos_q;
    logic [drive_pkg::AMP_WIDTH-1:0]                            amp_q;
    logic                                                       valid_q;
    logic signed [drive_pkg::AMP_WIDTH+drive_pkg::LUT_DATA_WIDTH:0] i_prod;
    logic signed [drive_pkg::AMP_WIDTH+drive_pkg::LUT_DATA_WIDTH:0] q_prod;

    nco_bank i_nco_bank (
        .clk         (clk),
        .rst         (rst),
        .ftw_wr_en_i (ftw_wr_en_i),
        .ftw_qubit_i (ftw_qubit_i),
        .ftw_i       (ftw_i),
        .rz_cmd_i    (rz_cmd_i),
        .qubit_sel_i (env_sample_i.qubit),
        .nco_phase_o (nco_phase)
    );

    // envelope phase + nco phase + axis offset, wraps at a full turn
    assign sin_addr = env_sample_i.word.phase + nco_phase
                    + env_sample_i.axis * drive_pkg::QUARTER_TURN;
    assign cos_addr = sin_addr + drive_pkg::QUARTER_TURN;

    always_ff @(posedge clk) begin
        if (lut_wr_en_i) begin
            lut[lut_wr_addr_i] <= lut_wr_data_i;
        end
    end

    // amp is unsigned, so widen with a zero before the signed multiply
    assign i_prod = $signed({1'b0, amp_q}) * cos_q;
    assign q_prod = $signed({1'b0, amp_q}) * sin_q;

    always_ff @(posedge clk) begin
        // stage 1 lut read
        sin_q <= lut[sin_addr];
        cos_q <= lut[cos_addr];
        amp_q <= env_sample_i.word.amp;
        // stage 2 scaled i/q
        iq_o.i <= i_prod[drive_pkg::IQ_SHIFT +: drive_pkg::IQ_WIDTH];
        iq_o.q <= q_prod[drive_pkg::IQ_SHIFT +: drive_pkg::IQ_WIDTH];

        if (rst) begin
            valid_q        <= 1'b0;
            sample_valid_o <= 1'b0;
            rz_done_o      <= 1'b0;
        end else begin
            valid_q        <= env_sample_i.valid;
            sample_valid_o <= valid_q;
            rz_done_o      <= rz_cmd_i.valid;
        end
    end

endmodule

// File: source/nco_bank.sv
`timescale 1ns/1ns

module nco_bank (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    ftw_wr_en_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]  ftw_qubit_i,
    input  logic [drive_pkg::NCO_WIDTH-1:0]         ftw_i,
    input  drive_pkg::rz_cmd_t                      rz_cmd_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]  qubit_sel_i,
    output logic [drive_pkg::PHASE_WIDTH-1:0]       nco_phase_o
);

    logic [drive_pkg::NCO_WIDTH-1:0] acc [drive_pkg::NUM_QUBIT];
    logic [drive_pkg::NCO_WIDTH-1:0] ftw [drive_pkg::NUM_QUBIT];
    logic [drive_pkg::NUM_QUBIT-1:0] ftw_sel;
    logic [drive_pkg::NUM_QUBIT-1:0] rz_sel;
    logic [drive_pkg::NCO_WIDTH-1:0] rz_step;

    // one-hot qubit decode for both write sources
    always_comb begin
        ftw_sel = '0;
        rz_sel  = '0;
        ftw_sel[ftw_qubit_i]    = ftw_wr_en_i;
        rz_sel[rz_cmd_i.qubit]  = rz_cmd_i.valid;
    end

    // immediate lands in the top bits of the accumulator
    assign rz_step = {rz_cmd_i.phase_imm,
                      {(drive_pkg::NCO_WIDTH - drive_pkg::PHASE_IMM_WIDTH){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '{default: '0};
            ftw <= '{default: '0};
        end else begin
            for (int q = 0; q < drive_pkg::NUM_QUBIT; q++) begin
                if (ftw_sel[q]) begin
                    // new tuning word restarts the phase
                    ftw[q] <= ftw_i;
                    acc[q] <= '0;
                end else if (rz_sel[q]) begin
                    acc[q] <= acc[q] + ftw[q] + rz_step;
                end else begin
                    acc[q] <= acc[q] + ftw[q];
                end
            end
        end
    end

    assign nco_phase_o = acc[qubit_sel_i][drive_pkg::NCO_WIDTH-1 -: drive_pkg::PHASE_WIDTH];

endmodule

// File: source/envelope_memory.sv
`timescale 1ns/1ns

module envelope_memory (
    input  logic                                  clk,
    input  logic                                  wr_en_i,
    input  logic [drive_pkg::ENV_ADDR_WIDTH-1:0]  wr_addr_i,
    input  drive_pkg::env_word_t                  wr_data_i,
    input  drive_pkg::env_read_t                  env_read_i,
    output drive_pkg::env_sample_t                env_sample_o
);

    drive_pkg::env_word_t mem [drive_pkg::ENV_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, context follows the data by one cycle
    always_ff @(posedge clk) begin
        env_sample_o.word  <= mem[env_read_i.addr];
        env_sample_o.valid <= env_read_i.valid;
        env_sample_o.qubit <= env_read_i.qubit;
        env_sample_o.axis  <= env_read_i.axis;
    end

endmodule

// File: source/pulse_sequencer.sv
`timescale 1ns/1ns

module pulse_sequencer (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         pc_valid_i,
    input  logic [drive_pkg::PC_WIDTH-1:0]               pc_i,
    input  logic                                         inst_wr_en_i,
    input  logic [drive_pkg::PC_WIDTH-1:0]               inst_wr_addr_i,
    input  drive_pkg::inst_word_t                        inst_wr_data_i,
    input  logic                                         table_wr_en_i,
    input  logic [drive_pkg::QUBIT_ADDR_WIDTH-1:0]       table_wr_qubit_i,
    input  logic [drive_pkg::INST_TABLE_ADDR_WIDTH-1:0]  table_wr_addr_i,
    input  drive_pkg::table_entry_t                      table_wr_data_i,
    output drive_pkg::env_read_t                         env_read_o,
    output drive_pkg::rz_cmd_t                           rz_cmd_o,
    output logic                                         busy_o
);

    ////////////////////////////////////////////////////////////////////////////
    // instruction list and per-qubit tables
    ////////////////////////////////////////////////////////////////////////////

    drive_pkg::inst_word_t   inst_mem  [drive_pkg::INST_LIST_DEPTH];
    drive_pkg::table_entry_t table_mem [drive_pkg::NUM_QUBIT][drive_pkg::INST_TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (inst_wr_en_i) begin
            inst_mem[inst_wr_addr_i] <= inst_wr_data_i;
        end
        if (table_wr_en_i) begin
            table_mem[table_wr_qubit_i][table_wr_addr_i] <= table_wr_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode and envelope walk
    ////////////////////////////////////////////////////////////////////////////

    drive_pkg::seq_state_t                         state;
    logic [drive_pkg::PC_WIDTH-1:0]                pc_q;
    drive_pkg::inst_word_t                         inst_q;
    drive_pkg::table_entry_t                       entry_q;
    logic [drive_pkg::INST_TABLE_ADDR_WIDTH-1:0]   table_idx;
    logic                                          accept;
    logic                                          last_addr;

    assign table_idx = inst_q.phase_imm[drive_pkg::INST_TABLE_ADDR_WIDTH-1:0];
    assign accept    = pc_valid_i && (state == drive_pkg::SEQ_IDLE);
    // also stops after a single word when stop is below start
    assign last_addr = env_read_o.valid && (env_read_o.addr >= entry_q.stop_addr);
    assign busy_o    = (state != drive_pkg::SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= pc_i;
        end
        if (state == drive_pkg::SEQ_FETCH) begin
            inst_q <= inst_mem[pc_q];
        end
        if (state == drive_pkg::SEQ_LOOKUP) begin
            entry_q            <= table_mem[inst_q.qubit][table_idx];
            rz_cmd_o.qubit     <= inst_q.qubit;
            rz_cmd_o.phase_imm <= inst_q.phase_imm;
        end
        // first word of a burst loads start, later words count up
        if (state == drive_pkg::SEQ_STREAM) begin
            env_read_o.addr  <= env_read_o.valid ? env_read_o.addr + 1'b1
                                                 : entry_q.start_addr;
            env_read_o.qubit <= inst_q.qubit;
            env_read_o.axis  <= entry_q.axis;
        end

        if (rst) begin
            state            <= drive_pkg::SEQ_IDLE;
            env_read_o.valid <= 1'b0;
            rz_cmd_o.valid   <= 1'b0;
        end else begin
            rz_cmd_o.valid <= 1'b0;
            case (state)
                drive_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        state <= drive_pkg::SEQ_FETCH;
                    end
                end
                drive_pkg::SEQ_FETCH: begin
                    state <= drive_pkg::SEQ_LOOKUP;
                end
                drive_pkg::SEQ_LOOKUP: begin
                    if (inst_q.op == drive_pkg::OP_RZ) begin
                        rz_cmd_o.valid <= 1'b1;
                        state          <= drive_pkg::SEQ_IDLE;
                    end else begin
                        state <= drive_pkg::SEQ_STREAM;
                    end
                end
                default: begin
                    if (last_addr) begin
                        env_read_o.valid <= 1'b0;
                        state            <= drive_pkg::SEQ_IDLE;
                    end else begin
                        env_read_o.valid <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: source/drive_pkg.sv
package drive_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_QUBIT             = 4;
    localparam int QUBIT_ADDR_WIDTH      = 2;
    localparam int INST_LIST_DEPTH       = 64;
    localparam int PC_WIDTH              = 6;
    localparam int INST_TABLE_DEPTH      = 8;
    localparam int INST_TABLE_ADDR_WIDTH = 3;
    localparam int ENV_DEPTH             = 256;
    localparam int ENV_ADDR_WIDTH        = 8;
    localparam int PHASE_WIDTH           = 8;
    localparam int AMP_WIDTH             = 8;
    localparam int LUT_DATA_WIDTH        = 8;
    localparam int NCO_WIDTH             = 16;
    localparam int PHASE_IMM_WIDTH       = 8;
    localparam int IQ_WIDTH              = 9;
    localparam int IQ_SHIFT              = 8;

    // cosine offset and one axis step
    localparam logic [PHASE_WIDTH-1:0] QUARTER_TURN = 8'd64;

    ////////////////////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        OP_PULSE,
        OP_RZ
    } op_t;

    // value is the number of quarter turns added
    typedef enum logic [1:0] {
        AXIS_X,
        AXIS_Y,
        AXIS_NX,
        AXIS_NY
    } axis_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_LOOKUP,
        SEQ_STREAM
    } seq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////

    // low bits of phase_imm select the table entry
    typedef struct packed {
        logic [QUBIT_ADDR_WIDTH-1:0] qubit;
        op_t                         op;
        logic [PHASE_IMM_WIDTH-1:0]  phase_imm;
    } inst_word_t;

    typedef struct packed {
        logic [ENV_ADDR_WIDTH-1:0] start_addr;
        logic [ENV_ADDR_WIDTH-1:0] stop_addr;
        axis_t                     axis;
    } table_entry_t;

    typedef struct packed {
        logic [PHASE_WIDTH-1:0] phase;
        logic [AMP_WIDTH-1:0]   amp;
    } env_word_t;

    typedef struct packed {
        logic                        valid;
        logic [ENV_ADDR_WIDTH-1:0]   addr;
        logic [QUBIT_ADDR_WIDTH-1:0] qubit;
        axis_t                       axis;
    } env_read_t;

    typedef struct packed {
        logic                        valid;
        env_word_t                   word;
        logic [QUBIT_ADDR_WIDTH-1:0] qubit;
        axis_t                       axis;
    } env_sample_t;

    typedef struct packed {
        logic                        valid;
        logic [QUBIT_ADDR_WIDTH-1:0] qubit;
        logic [PHASE_IMM_WIDTH-1:0]  phase_imm;
    } rz_cmd_t;

    typedef struct packed {
        logic signed [IQ_WIDTH-1:0] i;
        logic signed [IQ_WIDTH-1:0] q;
    } iq_t;

endpackage
